// File: hdl/bp_pkg.sv
// shared widths and encodings for the fetch-stage branch predictor, referenced by scoped name
`default_nettype none

package bp_pkg;

    // table geometry, index is pc[10:3]
    localparam int pc_index_width = 8;
    localparam int btb_depth      = 1 << pc_index_width;

    // fall-through step for one 8-byte fetch packet
    localparam logic [31:0] fetch_step = 32'd8;

    // predecode branch type, bit 0 set means unconditional
    localparam logic [1:0] btype_none     = 2'b00;
    localparam logic [1:0] btype_uncond   = 2'b01;
    localparam logic [1:0] btype_rel      = 2'b10;
    localparam logic [1:0] btype_indirect = 2'b11;

    // 2-bit counter states, bit 0 clear predicts taken
    localparam logic [1:0] ctr_strong_taken = 2'b00;
    localparam logic [1:0] ctr_strong_not   = 2'b01;
    localparam logic [1:0] ctr_weak_taken   = 2'b10;
    localparam logic [1:0] ctr_weak_not     = 2'b11;

    localparam logic [1:0] ctr_reset = ctr_weak_taken;

    // chooser strategies
    localparam logic [1:0] sel_idle = 2'b00; // static not taken
    localparam logic [1:0] sel_easy = 2'b01;
    localparam logic [1:0] sel_hard = 2'b10;

endpackage

`default_nettype wire

// File: hdl/branch_event_decode.sv
// slices table indexes, qualifies btb write/clear and tracks slots ending in an unconditional branch
`timescale 1ns/1ps
`default_nettype none

module branch_event_decode (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire                                 if0_allowin,
    input  wire [1:0]                           inst_btype,
    input  wire                                 inst_bpos,
    input  wire [31:0]                          fetch_pc,
    input  wire [31:0]                          fact_pc,
    input  wire                                 fact_valid,
    input  wire                                 fact_taken,
    input  wire                                 predict_add_fail,
    output logic [bp_pkg::pc_index_width-1:0]   fetch_index,
    output logic                                tgt_write,
    output logic [bp_pkg::pc_index_width-1:0]   fact_index,
    output logic                                tgt_clear,
    output logic                                uncond_hit
);

    logic [bp_pkg::btb_depth-1:0] uncond_rec; // one bit per packet slot
    logic                         uncond_now;
    logic                         uncond_set;

    assign fetch_index = fetch_pc[bp_pkg::pc_index_width+2:3];
    assign fact_index  = fact_pc[bp_pkg::pc_index_width+2:3];

    // only a taken branch with a wrong target installs a new one
    assign tgt_write = fact_valid & fact_taken & predict_add_fail;

    // predecode says no branch here, so any stored entry is stale
    assign tgt_clear = if0_allowin & (inst_btype == bp_pkg::btype_none);

    assign uncond_now = inst_bpos & inst_btype[0];
    assign uncond_set = if0_allowin & uncond_now;

    // current predecode counts even before the record is written
    assign uncond_hit = uncond_rec[fetch_index] | uncond_now;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            uncond_rec <= '0;
        end else begin
            if (uncond_set) begin
                uncond_rec[fetch_index] <= 1'b1;
            end else if (tgt_clear) begin
                uncond_rec[fetch_index] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/btb_target_store.sv
// branch target array with valid mask, combinational lookup at fetch index and clocked update
`timescale 1ns/1ps
`default_nettype none

module btb_target_store (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire [bp_pkg::pc_index_width-1:0]    fetch_index,
    input  wire [bp_pkg::pc_index_width-1:0]    fact_index,
    input  wire [31:0]                          fact_tpc,
    input  wire                                 tgt_write,
    input  wire                                 tgt_clear,
    output logic                                tgt_valid,
    output logic [31:0]                         tgt_pc
);

    logic [31:0]                  tgt_mem [bp_pkg::btb_depth];
    logic [bp_pkg::btb_depth-1:0] tgt_mask;

    always_ff @(posedge clk) begin
        if (tgt_write) begin
            tgt_mem[fact_index] <= fact_tpc;
        end
    end

    // write is applied last so it beats a clear on the same entry
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tgt_mask <= '0;
        end else begin
            if (tgt_clear) begin
                tgt_mask[fetch_index] <= 1'b0;
            end
            if (tgt_write) begin
                tgt_mask[fact_index] <= 1'b1;
            end
        end
    end

    assign tgt_valid = tgt_mask[fetch_index];
    assign tgt_pc    = tgt_mem[fetch_index]; // async read port

endmodule

`default_nettype wire

// File: hdl/direction_predictor.sv
// global taken/not-taken predictor choosing between two 2-bit counters by a miss score
`timescale 1ns/1ps
`default_nettype none

module direction_predictor (
    input  wire  clk,
    input  wire  rstn,
    input  wire  fact_valid,
    input  wire  fact_taken,
    input  wire  predict_dir_fail,
    output logic dir_taken
);

    logic [1:0] easy_ctr;
    logic [1:0] easy_nxt;
    logic [1:0] hard_ctr;
    logic [1:0] hard_nxt;
    logic [1:0] score;
    logic [1:0] score_nxt;
    logic [1:0] sel;
    logic [1:0] sel_nxt;

    // easy flips prediction on a single miss
    always_comb begin
        if (fact_taken) begin
            easy_nxt = easy_ctr[0] ? bp_pkg::ctr_weak_taken : bp_pkg::ctr_strong_taken;
        end else begin
            easy_nxt = easy_ctr[0] ? bp_pkg::ctr_strong_not : bp_pkg::ctr_weak_not;
        end
    end

    // hard needs two misses from a strong state
    always_comb begin
        case (hard_ctr)
            bp_pkg::ctr_strong_taken:
                hard_nxt = fact_taken ? bp_pkg::ctr_strong_taken : bp_pkg::ctr_weak_taken;
            bp_pkg::ctr_weak_taken:
                hard_nxt = fact_taken ? bp_pkg::ctr_strong_taken : bp_pkg::ctr_weak_not;
            bp_pkg::ctr_strong_not:
                hard_nxt = fact_taken ? bp_pkg::ctr_weak_not : bp_pkg::ctr_strong_not;
            default:
                hard_nxt = fact_taken ? bp_pkg::ctr_weak_taken : bp_pkg::ctr_strong_not;
        endcase
    end

    always_comb begin
        case (score)
            2'b00:   score_nxt = predict_dir_fail ? 2'b01 : 2'b00;
            2'b01:   score_nxt = predict_dir_fail ? 2'b10 : 2'b00;
            2'b10:   score_nxt = predict_dir_fail ? 2'b01 : 2'b11;
            default: score_nxt = predict_dir_fail ? 2'b10 : 2'b11;
        endcase
    end

    assign sel_nxt = score[1] ? bp_pkg::sel_easy : bp_pkg::sel_hard; // from old score

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            easy_ctr <= bp_pkg::ctr_reset;
            hard_ctr <= bp_pkg::ctr_reset;
            score    <= 2'b00;
            sel      <= bp_pkg::sel_idle;
        end else if (fact_valid) begin
            easy_ctr <= easy_nxt;
            hard_ctr <= hard_nxt;
            score    <= score_nxt;
            sel      <= sel_nxt;
        end
    end

    always_comb begin
        case (sel)
            bp_pkg::sel_easy: dir_taken = ~easy_ctr[0];
            bp_pkg::sel_hard: dir_taken = ~hard_ctr[0];
            default:          dir_taken = 1'b0; // idle
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/prediction_output.sv
// forms next fetch address and taken bit, registered for IF1 and held while fetch stalls
`timescale 1ns/1ps
`default_nettype none

module prediction_output (
    input  wire         clk,
    input  wire         rstn,
    input  wire         if0_allowin,
    input  wire  [31:0] fetch_pc,
    input  wire         tgt_valid,
    input  wire  [31:0] tgt_pc,
    input  wire         uncond_hit,
    input  wire         dir_taken,
    output logic [31:0] pred_pc,
    output logic        pred_taken
);

    logic [31:0] fall_pc;
    logic [31:0] next_pc;
    logic        next_taken;

    assign fall_pc = fetch_pc + bp_pkg::fetch_step;

    // no target, no taken prediction
    assign next_taken = tgt_valid & (uncond_hit | dir_taken);
    assign next_pc    = tgt_valid ? tgt_pc : fall_pc;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pred_pc    <= 32'd0;
            pred_taken <= 1'b0;
        end else if (if0_allowin) begin
            pred_pc    <= next_pc;
            pred_taken <= next_taken;
        end
    end

endmodule

`default_nettype wire

// File: hdl/branch_predictor.sv
// fetch-stage branch predictor top, connects decode, target store, direction and output stages
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire         clk,
    input  wire         rstn,
    input  wire         if0_allowin,
    input  wire  [31:0] fetch_pc,
    input  wire  [1:0]  inst_btype,
    input  wire         inst_bpos,
    input  wire         fact_valid,
    input  wire  [31:0] fact_pc,
    input  wire  [31:0] fact_tpc,
    input  wire         fact_taken,
    input  wire         predict_dir_fail,
    input  wire         predict_add_fail,
    output logic [31:0] pred_pc,
    output logic        pred_taken
);

    logic [bp_pkg::pc_index_width-1:0] fetch_index;
    logic [bp_pkg::pc_index_width-1:0] fact_index;
    logic                              tgt_write;
    logic                              tgt_clear;
    logic                              uncond_hit;
    logic                              tgt_valid;
    logic [31:0]                       tgt_pc;
    logic                              dir_taken;

    branch_event_decode u_decode (
        .clk              (clk),
        .rstn             (rstn),
        .if0_allowin      (if0_allowin),
        .inst_btype       (inst_btype),
        .inst_bpos        (inst_bpos),
        .fetch_pc         (fetch_pc),
        .fact_pc          (fact_pc),
        .fact_valid       (fact_valid),
        .fact_taken       (fact_taken),
        .predict_add_fail (predict_add_fail),
        .fetch_index      (fetch_index),
        .fact_index       (fact_index),
        .tgt_write        (tgt_write),
        .tgt_clear        (tgt_clear),
        .uncond_hit       (uncond_hit)
    );

    btb_target_store u_btb (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_index (fetch_index),
        .fact_index  (fact_index),
        .fact_tpc    (fact_tpc),
        .tgt_write   (tgt_write),
        .tgt_clear   (tgt_clear),
        .tgt_valid   (tgt_valid),
        .tgt_pc      (tgt_pc)
    );

    direction_predictor u_dir (
        .clk              (clk),
        .rstn             (rstn),
        .fact_valid       (fact_valid),
        .fact_taken       (fact_taken),
        .predict_dir_fail (predict_dir_fail),
        .dir_taken        (dir_taken)
    );

    prediction_output u_out (
        .clk         (clk),
        .rstn        (rstn),
        .if0_allowin (if0_allowin),
        .fetch_pc    (fetch_pc),
        .tgt_valid   (tgt_valid),
        .tgt_pc      (tgt_pc),
        .uncond_hit  (uncond_hit),
        .dir_taken   (dir_taken),
        .pred_pc     (pred_pc),
        .pred_taken  (pred_taken)
    );

endmodule

`default_nettype wire

// File: bench/tb_branch_predictor.sv
// self-checking testbench for branch_predictor, reference model plus assertions on the outputs
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

    localparam int reset_cycles    = 10;
    localparam int directed_cycles = 60;
    localparam int random_cycles   = 1500;
    localparam int watchdog_cycles = reset_cycles + directed_cycles + random_cycles + 200;

    logic        clk = 1'b0;
    logic        rstn = 1'b0;
    logic        if0_allowin = 1'b0;
    logic [31:0] fetch_pc = '0;
    logic [1:0]  inst_btype = bp_pkg::btype_rel;
    logic        inst_bpos = 1'b0;
    logic        fact_valid = 1'b0;
    logic [31:0] fact_pc = '0;
    logic [31:0] fact_tpc = '0;
    logic        fact_taken = 1'b0;
    logic        predict_dir_fail = 1'b0;
    logic        predict_add_fail = 1'b0;
    wire  [31:0] pred_pc;
    wire         pred_taken;

    // reference model state
    logic        m_valid [bp_pkg::btb_depth];
    logic [31:0] m_tgt [bp_pkg::btb_depth];
    logic        m_unc [bp_pkg::btb_depth];
    logic [1:0]  m_easy, m_hard, m_score, m_sel;
    logic [31:0] exp_pc;
    logic        exp_taken;

    int unsigned rng_state = 32'd52536;
    int          errors = 0;
    int          checks = 0;

    branch_predictor uut (.*);

    always #2 clk = ~clk;

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 8;
    endfunction

    function automatic logic predicts_taken(input logic [1:0] ctr);
        return (ctr == bp_pkg::ctr_strong_taken) || (ctr == bp_pkg::ctr_weak_taken);
    endfunction

    // one miss moves straight to the other side
    function automatic logic [1:0] easy_step(input logic [1:0] ctr, input logic taken);
        if (taken)
            return predicts_taken(ctr) ? bp_pkg::ctr_strong_taken : bp_pkg::ctr_weak_taken;
        return predicts_taken(ctr) ? bp_pkg::ctr_weak_not : bp_pkg::ctr_strong_not;
    endfunction

    function automatic logic [1:0] hard_step(input logic [1:0] ctr, input logic taken);
        logic hit;
        hit = (predicts_taken(ctr) == taken);
        if (hit)
            return taken ? bp_pkg::ctr_strong_taken : bp_pkg::ctr_strong_not;
        if (ctr == bp_pkg::ctr_strong_taken)
            return bp_pkg::ctr_weak_taken;
        if (ctr == bp_pkg::ctr_strong_not)
            return bp_pkg::ctr_weak_not;
        return taken ? bp_pkg::ctr_weak_taken : bp_pkg::ctr_weak_not; // weak flips over
    endfunction

    function automatic logic [1:0] score_step(input logic [1:0] s, input logic miss);
        logic [1:0] on_hit [4];
        logic [1:0] on_miss [4];
        on_hit  = '{2'b00, 2'b00, 2'b11, 2'b11};
        on_miss = '{2'b01, 2'b10, 2'b01, 2'b10};
        return miss ? on_miss[s] : on_hit[s];
    endfunction

    always @(posedge clk or negedge rstn) begin : ref_model
        logic [7:0] fi;
        logic [7:0] ai;
        logic       dir;
        if (!rstn) begin
            for (int i = 0; i < bp_pkg::btb_depth; i++) begin
                m_valid[i] = 1'b0;
                m_unc[i]   = 1'b0;
                m_tgt[i]   = '0;
            end
            m_easy = bp_pkg::ctr_reset;
            m_hard = bp_pkg::ctr_reset;
            m_score = 2'b00;
            m_sel = bp_pkg::sel_idle;
            exp_pc = '0;
            exp_taken = 1'b0;
        end else begin
            fi = fetch_pc[10:3];
            ai = fact_pc[10:3];
            if (m_sel == bp_pkg::sel_easy)
                dir = predicts_taken(m_easy);
            else if (m_sel == bp_pkg::sel_hard)
                dir = predicts_taken(m_hard);
            else
                dir = 1'b0;
            if (if0_allowin) begin
                exp_pc = m_valid[fi] ? m_tgt[fi] : fetch_pc + 32'd8;
                exp_taken = m_valid[fi] && (m_unc[fi] || (inst_bpos && inst_btype[0]) || dir);
            end
            // clear first so a write to the same entry survives
            if (if0_allowin && inst_btype == bp_pkg::btype_none)
                m_valid[fi] = 1'b0;
            if (fact_valid && fact_taken && predict_add_fail) begin
                m_valid[ai] = 1'b1;
                m_tgt[ai]   = fact_tpc;
            end
            if (if0_allowin && inst_bpos && inst_btype[0])
                m_unc[fi] = 1'b1;
            else if (if0_allowin && inst_btype == bp_pkg::btype_none)
                m_unc[fi] = 1'b0;
            if (fact_valid) begin
                m_sel   = m_score[1] ? bp_pkg::sel_easy : bp_pkg::sel_hard;
                m_score = score_step(m_score, predict_dir_fail);
                m_easy  = easy_step(m_easy, fact_taken);
                m_hard  = hard_step(m_hard, fact_taken);
            end
        end
    end

    // outputs are registers, stable by the falling edge
    always @(negedge clk) begin
        checks++;
        assert (pred_pc === exp_pc) else begin
            errors++;
            $display("Fail pred_pc expected %h got %h", exp_pc, pred_pc);
        end
        assert (pred_taken === exp_taken) else begin
            errors++;
            $display("Fail pred_taken expected %h got %h", exp_taken, pred_taken);
        end
    end

    task automatic drive(input logic allow, input logic [31:0] pc, input logic [1:0] btype,
                         input logic bpos, input logic fv, input logic [31:0] fpc,
                         input logic [31:0] ftpc, input logic ftaken, input logic dfail,
                         input logic afail);
        @(negedge clk);
        if0_allowin = allow;
        fetch_pc = pc;
        inst_btype = btype;
        inst_bpos = bpos;
        fact_valid = fv;
        fact_pc = fpc;
        fact_tpc = ftpc;
        fact_taken = ftaken;
        predict_dir_fail = dfail;
        predict_add_fail = afail;
    endtask

    task automatic fetch(input logic [31:0] pc, input logic [1:0] btype, input logic bpos);
        drive(1'b1, pc, btype, bpos, 1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    // fetch stalled so nothing gets cleared
    task automatic resolve(input logic [31:0] pc, input logic [31:0] tpc, input logic taken,
                           input logic dfail, input logic afail);
        drive(1'b0, '0, bp_pkg::btype_rel, 1'b0, 1'b1, pc, tpc, taken, dfail, afail);
    endtask

    initial begin : stimulus
        int unsigned r;
        int          stall_left;
        stall_left = 0;
        repeat (reset_cycles) @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < 4; i++)
            fetch(32'h0000_1000 + 32'(i) * 8, bp_pkg::btype_rel, 1'b0); // unwritten
        resolve(32'h0000_2040, 32'h0000_8000, 1'b1, 1'b1, 1'b1);
        fetch(32'h0000_2040, bp_pkg::btype_rel, 1'b0);
        fetch(32'h0010_2040, bp_pkg::btype_rel, 1'b0); // alias above bit 10
        fetch(32'h0000_2040, bp_pkg::btype_none, 1'b0);
        fetch(32'h0000_2040, bp_pkg::btype_rel, 1'b0);
        drive(1'b1, 32'h0000_2040, bp_pkg::btype_none, 1'b0,
              1'b1, 32'h0000_2040, 32'h0000_9000, 1'b1, 1'b0, 1'b1);
        fetch(32'h0000_2040, bp_pkg::btype_rel, 1'b0);
        for (int i = 0; i < random_cycles; i++) begin
            r = next_rand();
            if (stall_left == 0 && r[2:0] == 3'd0)
                stall_left = 1 + next_rand() % 6;
            drive(stall_left == 0, (next_rand() & 32'hFFFF_F800) | ((next_rand() % 16) << 3),
                  r[5:4], r[6], r[7], (next_rand() & 32'hFFFF_F800) | ((next_rand() % 16) << 3),
                  next_rand() & 32'hFFFF_FFF8, r[8], r[9], r[10]);
            if (stall_left > 0)
                stall_left--;
        end
        // uncond slot still predicts taken once direction has settled not taken
        resolve(32'h0000_0300, 32'h0000_a000, 1'b1, 1'b0, 1'b1);
        repeat (4) resolve(32'h0000_0700, 32'h0, 1'b0, 1'b0, 1'b0);
        fetch(32'h0000_0300, bp_pkg::btype_uncond, 1'b1);
        fetch(32'h0000_0300, bp_pkg::btype_rel, 1'b0);
        fetch(32'h0000_0300, bp_pkg::btype_none, 1'b0);
        fetch(32'h0000_0300, bp_pkg::btype_rel, 1'b0);
        // reinstalled target must not inherit the cleared uncond bit
        resolve(32'h0000_0300, 32'h0000_a000, 1'b1, 1'b0, 1'b1);
        repeat (4) resolve(32'h0000_0700, 32'h0, 1'b0, 1'b0, 1'b0);
        fetch(32'h0000_0300, bp_pkg::btype_rel, 1'b0);
        repeat (3) @(negedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * 4);
        $display("watchdog timeout, stimulus did not finish");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/bp_pkg.sv
hdl/branch_event_decode.sv
hdl/btb_target_store.sv
hdl/direction_predictor.sv
hdl/prediction_output.sv
hdl/branch_predictor.sv
bench/tb_branch_predictor.sv
